// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= bpu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bpu_top.f ====
+incdir+hw
hw/bpu_pkg.sv
hw/tage_index_hash.sv
hw/tage_tagged_table.sv
hw/bimodal_table.sv
hw/btb.sv
hw/tage_provider_arbiter.sv
hw/bpu_top.sv
test/bpu_checker.sv
test/bpu_tb.sv

// ==== hw/bimodal_table.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module bimodal_table (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    input  logic           upd_valid_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  logic           taken_i,
    output logic           pred_o
);
    import bpu_pkg::*;

    localparam int IB      = `BPU_BIM_IDX_BITS;
    localparam int ENTRIES = 1 << IB;

    ctr_t          ctr_q [ENTRIES];
    logic [IB-1:0] lkp_idx;
    logic [IB-1:0] upd_idx;

    // halfword granular index, bit 0 dropped
    assign lkp_idx = lookup_pc_i[IB:1];
    assign upd_idx = upd_pc_i[IB:1];

    assign pred_o = ctr_q[lkp_idx][1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= `BPU_CTR_INIT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= ctr_sat(ctr_q[upd_idx], taken_i);  // trains on every branch
        end
    end

endmodule

// ==== hw/bpu_defs.svh ====
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// address and instruction width
`define BPU_XLEN 32

// global history register
`define BPU_HIST_BITS 16

// tagged tables, one per history half
`define BPU_NUM_TAGGED 2
`define BPU_TAGE_IDX_BITS 8
`define BPU_TAG_BITS 10
`define BPU_PARTIAL_TAG_BITS 6   // upper tag bits compared at lookup

// bimodal indexed by pc[9:1]
`define BPU_BIM_IDX_BITS 9

// btb indexed by pc[9:2], tagged by the top pc bits
`define BPU_BTB_IDX_BITS 8
`define BPU_BTB_TAG_BITS 22

// counter value after reset, weakly not taken
`define BPU_CTR_INIT 2'b01

`endif

// ==== hw/bpu_pkg.sv ====
`include "bpu_defs.svh"

package bpu_pkg;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // provider number equals tagged table number plus one
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef enum logic [1:0] {
        TOP_NONE         = 2'd0,
        TOP_TRAIN        = 2'd1,
        TOP_RESET_STRONG = 2'd2,
        TOP_ALLOC        = 2'd3
    } table_op_e;

    typedef logic [1:0]                    ctr_t;
    typedef logic [`BPU_XLEN-1:0]          addr_t;
    typedef logic [`BPU_HIST_BITS-1:0]     hist_t;
    typedef logic [`BPU_TAGE_IDX_BITS-1:0] tage_idx_t;
    typedef logic [`BPU_TAG_BITS-1:0]      tage_tag_t;

    // two-bit saturating step
    function automatic ctr_t ctr_sat(input ctr_t ctr, input logic up);
        ctr_t nxt;
        nxt = ctr;
        if (up && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// ==== hw/bpu_top.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module bpu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  bpu_pkg::addr_t        if_pc_i,
    input  logic [`BPU_XLEN-1:0]  if_inst_i,
    input  logic                  ex_branch_valid_i,
    input  logic                  ex_taken_i,
    input  logic                  ex_pdt_true_i,
    input  bpu_pkg::addr_t        ex_pc_i,
    input  bpu_pkg::addr_t        ex_target_i,
    input  bpu_pkg::hist_t        ex_history_i,
    input  bpu_pkg::provider_e    ex_provider_i,
    output logic                  branch_or_not_o,
    output logic                  pdt_res_o,
    output bpu_pkg::addr_t        pdt_pc_o,
    output bpu_pkg::provider_e    pdt_provider_o,
    output bpu_pkg::hist_t        history_o
);
    import bpu_pkg::*;

    localparam int NT = `BPU_NUM_TAGGED;

    hist_t              ghist_q;
    tage_idx_t [NT-1:0] lkp_idx;
    tage_tag_t [NT-1:0] lkp_tag;
    tage_idx_t [NT-1:0] upd_idx;
    tage_tag_t [NT-1:0] upd_tag;
    logic      [NT-1:0] tbl_match;
    logic      [NT-1:0] tbl_pred;
    logic      [NT-1:0] tbl_upd_hit;
    table_op_e [NT-1:0] tbl_op;

    logic      bim_pred;
    logic      tage_pred;
    logic      btb_hit;
    addr_t     btb_target;
    opcode_e   opcode;
    addr_t     imm_b;
    addr_t     imm_j;

    assign opcode = opcode_e'(if_inst_i[6:0]);

    assign imm_b = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    assign imm_j = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    // taken bit shifts in at each resolved branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (ex_branch_valid_i) begin
            ghist_q <= {ghist_q[`BPU_HIST_BITS-2:0], ex_taken_i};
        end
    end

    assign history_o = ghist_q;

    tage_index_hash u_hash (
        .if_pc_i      (if_pc_i),
        .history_i    (ghist_q),
        .ex_pc_i      (ex_pc_i),
        .ex_history_i (ex_history_i),
        .lkp_idx_o    (lkp_idx),
        .lkp_tag_o    (lkp_tag),
        .upd_idx_o    (upd_idx),
        .upd_tag_o    (upd_tag)
    );

    for (genvar g = 0; g < NT; g++) begin : g_tagged
        tage_tagged_table u_table (
            .clk       (clk),
            .rst       (rst),
            .lkp_idx_i (lkp_idx[g]),
            .lkp_tag_i (lkp_tag[g]),
            .upd_idx_i (upd_idx[g]),
            .upd_tag_i (upd_tag[g]),
            .op_i      (tbl_op[g]),
            .taken_i   (ex_taken_i),
            .match_o   (tbl_match[g]),
            .pred_o    (tbl_pred[g]),
            .upd_hit_o (tbl_upd_hit[g])
        );
    end

    tage_provider_arbiter u_arbiter (
        .match_i           (tbl_match),
        .tbl_pred_i        (tbl_pred),
        .bim_pred_i        (bim_pred),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_pdt_true_i     (ex_pdt_true_i),
        .ex_provider_i     (ex_provider_i),
        .upd_hit_i         (tbl_upd_hit),
        .pred_o            (tage_pred),
        .provider_o        (pdt_provider_o),   // travels with the prediction
        .op_o              (tbl_op)
    );

    bimodal_table u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd_valid_i (ex_branch_valid_i),
        .upd_pc_i    (ex_pc_i),
        .taken_i     (ex_taken_i),
        .pred_o      (bim_pred)
    );

    btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (if_pc_i),
        .upd_valid_i  (ex_branch_valid_i),
        .upd_taken_i  (ex_taken_i),
        .upd_pc_i     (ex_pc_i),
        .upd_target_i (ex_target_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target)
    );

    // direction and target, fall through unless predicted taken
    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = if_pc_i + addr_t'(4);
        case (opcode)
            OP_JAL: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = 1'b1;
                pdt_pc_o        = btb_hit ? btb_target : if_pc_i + imm_j;
            end
            OP_BRANCH: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = tage_pred;
                if (tage_pred) begin
                    pdt_pc_o = btb_hit ? btb_target : if_pc_i + imm_b;
                end
            end
            OP_JALR: begin
                // register target unknown here, btb or nothing
                branch_or_not_o = 1'b1;
                pdt_res_o       = btb_hit;
                if (btb_hit) begin
                    pdt_pc_o = btb_target;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/btb.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    input  logic           upd_valid_i,
    input  logic           upd_taken_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  bpu_pkg::addr_t upd_target_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o
);
    localparam int IB      = `BPU_BTB_IDX_BITS;
    localparam int TB      = `BPU_BTB_TAG_BITS;
    localparam int ENTRIES = 1 << IB;

    logic [ENTRIES-1:0] valid_q;
    logic [TB-1:0]      tag_q    [ENTRIES];
    bpu_pkg::addr_t     target_q [ENTRIES];

    logic [IB-1:0] lkp_idx;
    logic [TB-1:0] lkp_tag;
    logic [IB-1:0] upd_idx;
    logic [TB-1:0] upd_tag;

    // word index, tag from the top of pc
    assign lkp_idx = lookup_pc_i[IB+1:2];
    assign lkp_tag = lookup_pc_i[`BPU_XLEN-1 -: TB];
    assign upd_idx = upd_pc_i[IB+1:2];
    assign upd_tag = upd_pc_i[`BPU_XLEN-1 -: TB];

    assign hit_o    = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);
    assign target_o = target_q[lkp_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_valid_i && upd_taken_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i && upd_taken_i) begin  // only taken branches fill
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

// ==== hw/tage_index_hash.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module tage_index_hash (
    input  bpu_pkg::addr_t                           if_pc_i,
    input  bpu_pkg::hist_t                           history_i,
    input  bpu_pkg::addr_t                           ex_pc_i,
    input  bpu_pkg::hist_t                           ex_history_i,
    output bpu_pkg::tage_idx_t [`BPU_NUM_TAGGED-1:0] lkp_idx_o,
    output bpu_pkg::tage_tag_t [`BPU_NUM_TAGGED-1:0] lkp_tag_o,
    output bpu_pkg::tage_idx_t [`BPU_NUM_TAGGED-1:0] upd_idx_o,
    output bpu_pkg::tage_tag_t [`BPU_NUM_TAGGED-1:0] upd_tag_o
);
    import bpu_pkg::*;

    localparam int IW = `BPU_TAGE_IDX_BITS;
    localparam int TW = `BPU_TAG_BITS;
    localparam int HB = `BPU_HIST_BITS;

    // table t folds in history half t
    function automatic tage_idx_t fold_idx(input addr_t pc, input hist_t h, input int t);
        return pc[IW-1:0] ^ h[t*IW +: IW];
    endfunction

    function automatic tage_tag_t fold_tag(input addr_t pc, input hist_t h, input int t);
        tage_tag_t hmix;
        if (t == 0) begin
            hmix = h[HB-1 -: TW];            // top history bits
        end else begin
            hmix = tage_tag_t'(h[IW-1:0]);   // low half, zero extended
        end
        return pc[IW +: TW] ^ hmix;
    endfunction

    for (genvar g = 0; g < `BPU_NUM_TAGGED; g++) begin : g_tbl
        // lookup sees live history
        assign lkp_idx_o[g] = fold_idx(if_pc_i, history_i, g);
        assign lkp_tag_o[g] = fold_tag(if_pc_i, history_i, g);
        // update uses history carried down the pipe
        assign upd_idx_o[g] = fold_idx(ex_pc_i, ex_history_i, g);
        assign upd_tag_o[g] = fold_tag(ex_pc_i, ex_history_i, g);
    end

endmodule

// ==== hw/tage_provider_arbiter.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module tage_provider_arbiter (
    input  logic [`BPU_NUM_TAGGED-1:0]               match_i,
    input  logic [`BPU_NUM_TAGGED-1:0]               tbl_pred_i,
    input  logic                                     bim_pred_i,
    input  logic                                     ex_branch_valid_i,
    input  logic                                     ex_pdt_true_i,
    input  bpu_pkg::provider_e                       ex_provider_i,
    input  logic [`BPU_NUM_TAGGED-1:0]               upd_hit_i,
    output logic                                     pred_o,
    output bpu_pkg::provider_e                       provider_o,
    output bpu_pkg::table_op_e [`BPU_NUM_TAGGED-1:0] op_o
);
    import bpu_pkg::*;

    // lookup, highest numbered match overrides
    always_comb begin
        pred_o     = bim_pred_i;
        provider_o = PROV_BIMODAL;
        for (int t = 0; t < `BPU_NUM_TAGGED; t++) begin
            if (match_i[t]) begin
                pred_o     = tbl_pred_i[t];
                provider_o = provider_e'(t + 1);
            end
        end
    end

    // feedback commands per table
    always_comb begin
        logic alloc_found;
        int   alloc_sel;
        alloc_found = 1'b0;
        alloc_sel   = 0;
        for (int t = 0; t < `BPU_NUM_TAGGED; t++) begin
            op_o[t] = TOP_NONE;
            if (!upd_hit_i[t]) begin  // free slot, later table preferred
                alloc_found = 1'b1;
                alloc_sel   = t;
            end
        end
        if (ex_branch_valid_i) begin
            if (ex_provider_i == PROV_BIMODAL) begin
                if (!ex_pdt_true_i && alloc_found) begin
                    op_o[alloc_sel] = TOP_ALLOC;
                end
            end else begin
                for (int t = 0; t < `BPU_NUM_TAGGED; t++) begin
                    if (ex_provider_i == provider_e'(t + 1)) begin
                        op_o[t] = ex_pdt_true_i ? TOP_TRAIN : TOP_RESET_STRONG;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/tage_tagged_table.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module tage_tagged_table (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::tage_idx_t  lkp_idx_i,
    input  bpu_pkg::tage_tag_t  lkp_tag_i,
    input  bpu_pkg::tage_idx_t  upd_idx_i,
    input  bpu_pkg::tage_tag_t  upd_tag_i,
    input  bpu_pkg::table_op_e  op_i,
    input  logic                taken_i,
    output logic                match_o,
    output logic                pred_o,
    output logic                upd_hit_o
);
    import bpu_pkg::*;

    localparam int ENTRIES = 1 << `BPU_TAGE_IDX_BITS;
    localparam int PT_MSB  = `BPU_TAG_BITS - 1;
    localparam int PT_LSB  = `BPU_TAG_BITS - `BPU_PARTIAL_TAG_BITS;

    logic [ENTRIES-1:0] valid_q;
    tage_tag_t          tag_q [ENTRIES];
    ctr_t               ctr_q [ENTRIES];

    // lookup compares only the upper tag bits
    assign match_o = valid_q[lkp_idx_i] &&
                     (tag_q[lkp_idx_i][PT_MSB:PT_LSB] == lkp_tag_i[PT_MSB:PT_LSB]);
    assign pred_o  = ctr_q[lkp_idx_i][1];

    // full tag for the allocation decision
    assign upd_hit_o = valid_q[upd_idx_i] && (tag_q[upd_idx_i] == upd_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= `BPU_CTR_INIT;
            end
        end else begin
            case (op_i)
                TOP_TRAIN: begin
                    ctr_q[upd_idx_i] <= ctr_sat(ctr_q[upd_idx_i], taken_i);
                end
                TOP_RESET_STRONG: begin
                    ctr_q[upd_idx_i] <= taken_i ? 2'b11 : 2'b00;
                end
                TOP_ALLOC: begin
                    valid_q[upd_idx_i] <= 1'b1;
                    ctr_q[upd_idx_i]   <= taken_i ? 2'b10 : 2'b01;  // weak toward outcome
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_i == TOP_ALLOC) begin
            tag_q[upd_idx_i] <= upd_tag_i;
        end
    end

endmodule

// ==== test/bpu_checker.sv ====
`timescale 1ns/10ps

module bpu_checker (
    input logic           clk,
    input logic           rst,
    input bpu_pkg::addr_t if_pc_i,
    input logic           branch_i,
    input logic           pdt_res_i,
    input bpu_pkg::addr_t pdt_pc_i,
    input bpu_pkg::hist_t history_i
);
    import bpu_pkg::*;

    // taken only for control flow
    taken_needs_branch: assert property (@(posedge clk) disable iff (rst)
        pdt_res_i |-> branch_i)
        else $error("pdt_res_o high while branch_or_not_o is low");

    fall_through_pc: assert property (@(posedge clk) disable iff (rst)
        !branch_i |-> (pdt_pc_i == if_pc_i + addr_t'(4)))
        else $error("pdt_pc_o is not if_pc_i + 4 for a non-branch");

    // first cycle out of reset
    history_cleared: assert property (@(posedge clk)
        $fell(rst) |-> (history_i == '0))
        else $error("history_o nonzero in the first cycle after reset");

endmodule

bind bpu_top bpu_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .if_pc_i   (if_pc_i),
    .branch_i  (branch_or_not_o),
    .pdt_res_i (pdt_res_o),
    .pdt_pc_i  (pdt_pc_o),
    .history_i (history_o)
);

// ==== test/bpu_tb.sv ====
`timescale 1ns/10ps
`include "bpu_defs.svh"

module bpu_tb;
    import bpu_pkg::*;

    localparam int MAX_STEPS  = 64;
    localparam int STEP_WORDS = 8;   // words per line of the tests file

    logic                 clk;
    logic                 rst;
    addr_t                if_pc;
    logic [`BPU_XLEN-1:0] if_inst;
    logic                 ex_valid;
    logic                 ex_taken;
    logic                 ex_pdt_true;
    addr_t                ex_pc;
    addr_t                ex_target;
    hist_t                ex_history;
    provider_e            ex_provider;
    logic                 branch_or_not;
    logic                 pdt_res;
    addr_t                pdt_pc;
    provider_e            pdt_provider;
    hist_t                history;

    logic [31:0] steps_mem [MAX_STEPS*STEP_WORDS];
    int          num_steps;
    int          cycle_limit;
    int          cycle_count = 0;
    int          checks;
    int          errors;

    bpu_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc),
        .if_inst_i         (if_inst),
        .ex_branch_valid_i (ex_valid),
        .ex_taken_i        (ex_taken),
        .ex_pdt_true_i     (ex_pdt_true),
        .ex_pc_i           (ex_pc),
        .ex_target_i       (ex_target),
        .ex_history_i      (ex_history),
        .ex_provider_i     (ex_provider),
        .branch_or_not_o   (branch_or_not),
        .pdt_res_o         (pdt_res),
        .pdt_pc_o          (pdt_pc),
        .pdt_provider_o    (pdt_provider),
        .history_o         (history)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the test steps did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic compare_field(input int step, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %t: step %0d %s is %0h, expected %0h",
                     $time, step, name, got, exp);
        end
    endtask

    // outputs read in the middle of the low phase
    task automatic drive_prediction(input int step, input int b);
        ex_valid = 1'b0;
        if_pc    = steps_mem[b+1];
        if_inst  = steps_mem[b+2];
        #1;
        compare_field(step, "branch_or_not", 32'(branch_or_not), steps_mem[b+3]);
        compare_field(step, "pdt_res", 32'(pdt_res), steps_mem[b+4]);
        compare_field(step, "pdt_pc", pdt_pc, steps_mem[b+5]);
        compare_field(step, "provider", 32'(pdt_provider), steps_mem[b+6]);
        compare_field(step, "history", 32'(history), steps_mem[b+7]);
    endtask

    task automatic send_feedback(input int b);
        ex_valid    = 1'b1;   // stays high if the next step is an update too
        ex_pc       = steps_mem[b+1];
        ex_taken    = steps_mem[b+2][0];
        ex_pdt_true = steps_mem[b+3][0];
        ex_target   = steps_mem[b+4];
        ex_history  = steps_mem[b+5][`BPU_HIST_BITS-1:0];
        ex_provider = provider_e'(steps_mem[b+6][1:0]);
    endtask

    initial begin
        int b;
        $timeformat(-9, 0, " ns", 0);
        rst         = 1'b1;
        if_pc       = '0;
        if_inst     = '0;
        ex_valid    = 1'b0;
        ex_taken    = 1'b0;
        ex_pdt_true = 1'b0;
        ex_pc       = '0;
        ex_target   = '0;
        ex_history  = '0;
        ex_provider = PROV_BIMODAL;
        checks      = 0;
        errors      = 0;
        $readmemh("test/bpu_tests.txt", steps_mem);
        num_steps = 0;
        while (num_steps < MAX_STEPS &&
               (steps_mem[num_steps*STEP_WORDS] == 32'd1 ||
                steps_mem[num_steps*STEP_WORDS] == 32'd2)) begin
            num_steps++;
        end
        cycle_limit = num_steps * 4 + 20;
        if (num_steps == 0) begin
            $display("no test steps could be read from test/bpu_tests.txt");
            errors++;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int s = 0; s < num_steps; s++) begin
                b = s * STEP_WORDS;
                @(negedge clk);
                if (steps_mem[b] == 32'd1) begin
                    drive_prediction(s, b);
                end else begin
                    send_feedback(b);
                end
            end
            @(negedge clk);
            ex_valid = 1'b0;
        end
        $display("%0d steps, %0d checks, %0d errors", num_steps, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== test/bpu_tests.txt ====
// predict: 1 pc inst exp_branch_or_not exp_pdt_res exp_pdt_pc exp_provider exp_history
// update:  2 pc taken pdt_true target history provider 0, a line of zeros ends the list
1 00001000 00000013 0 0 00001004 0 0000  // addi after reset
1 00001100 100000ef 1 1 00001200 0 0000  // cold jal, pc + 0x100
1 00001104 00008067 1 0 00001108 0 0000  // cold jalr
1 00002000 00208863 1 0 00002004 0 0000  // cold beq
1 00002404 00208863 1 0 00002408 0 0000
2 00002404 1 0 00002414 0000 0 0         // bimodal miss, T1 allocates
1 00002404 00208863 1 1 00002414 2 0001  // T1 provides taken
2 00002404 0 0 00002414 0001 2 0         // T1 miss, strong not taken
1 00002404 00208863 1 0 00002408 2 0002
2 00001100 1 1 00003000 0002 0 0         // btb fill for jal
2 00001104 1 1 00004000 0005 0 0         // back to back, jalr
1 00001100 100000ef 1 1 00003000 0 000b
1 00001104 00008067 1 1 00004000 0 000b
2 00002000 1 0 00002010 000b 0 0
2 00002000 1 1 00002010 0017 0 0
1 00002000 00208863 1 1 00002010 0 002f  // bimodal now taken
1 00002400 00208863 1 1 00002410 0 002f  // btb miss, pc + b-imm
2 00002000 1 1 00005000 002f 0 0         // new btb target
1 00002000 00208863 1 1 00005000 0 005f
1 00002004 00000013 0 0 00002008 0 005f
0 0 0 0 0 0 0 0
